/* design/mips_alu.sv */
module mips_alu (
    input  mips_pkg::alu_op_e         op,
    input  logic [mips_pkg::xlen-1:0] a,
    input  logic [mips_pkg::xlen-1:0] b,
    output logic [mips_pkg::xlen-1:0] y,
    output logic                      zero,
    output logic                      overflow
);
    import mips_pkg::*;

    logic [xlen-1:0] sum;
    logic [xlen-1:0] diff;

    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        case (op)
            alu_add:  y = sum;
            alu_sub:  y = diff;
            alu_slt:  y = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: y = {{(xlen-1){1'b0}}, a < b};
            alu_and:  y = a & b;
            alu_or:   y = a | b;
            alu_xor:  y = a ^ b;
            alu_nor:  y = ~(a | b);
            default:  y = sum;
        endcase
    end

    assign zero = (y == '0);

    // same-sign add or mixed-sign sub whose result flips the sign of a
    always_comb begin
        case (op)
            alu_add: overflow = (a[xlen-1] == b[xlen-1]) && (sum[xlen-1] != a[xlen-1]);
            alu_sub: overflow = (a[xlen-1] != b[xlen-1]) && (diff[xlen-1] != a[xlen-1]);
            default: overflow = 1'b0;
        endcase
    end

endmodule

/* design/mips_control.sv */
module mips_control (
    input  logic               clk,
    input  logic               rst,
    input  mips_pkg::decoded_t dec,
    input  logic               alu_zero,
    output mips_pkg::ctrl_t    ctrl
);
    import mips_pkg::*;

    state_e state;
    state_e state_nxt;
    logic   br_taken;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_fetch;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        case (state)
            st_fetch: state_nxt = st_decode;
            st_decode: begin
                case (dec.cls)
                    cls_alu:            state_nxt = st_alu_exe;
                    cls_lui:            state_nxt = st_lui_wr;
                    cls_load, cls_store: state_nxt = st_dm_exe;
                    cls_branch:         state_nxt = st_branch_exe;
                    cls_jump:           state_nxt = st_jump_exe;
                    default:            state_nxt = st_fetch;
                endcase
            end
            st_alu_exe: state_nxt = st_alu_wr;
            st_dm_exe:  state_nxt = (dec.cls == cls_load) ? st_dm_load : st_dm_store;
            st_dm_load: state_nxt = st_dm_wr;
            default:    state_nxt = st_fetch;
        endcase
    end

    // beq takes on zero difference, bne on non-zero
    assign br_taken = dec.br_eq ? alu_zero : !alu_zero;

    always_comb begin
        ctrl.ir_wr    = (state == st_fetch);
        ctrl.pc_wr    = 1'b0;
        ctrl.rf_wr    = 1'b0;
        ctrl.dm_wr    = 1'b0;
        ctrl.wd_sel   = wd_alu;
        ctrl.npc_kind = npc_seq;
        case (state)
            // unmatched encodings just step past
            st_decode: ctrl.pc_wr = (dec.cls == cls_nop);
            st_alu_wr: begin
                ctrl.pc_wr = 1'b1;
                ctrl.rf_wr = 1'b1;
            end
            st_lui_wr: begin
                ctrl.pc_wr  = 1'b1;
                ctrl.rf_wr  = 1'b1;
                ctrl.wd_sel = wd_upper;
            end
            st_dm_wr: begin
                ctrl.pc_wr  = 1'b1;
                ctrl.rf_wr  = 1'b1;
                ctrl.wd_sel = wd_mem;
            end
            st_dm_store: begin
                ctrl.pc_wr = 1'b1;
                ctrl.dm_wr = 1'b1;
            end
            st_branch_exe: begin
                ctrl.pc_wr    = 1'b1;
                ctrl.npc_kind = br_taken ? npc_branch : npc_seq;
            end
            st_jump_exe: begin
                ctrl.pc_wr    = 1'b1;
                ctrl.npc_kind = npc_jump;
                ctrl.rf_wr    = dec.link;
                ctrl.wd_sel   = wd_pc4;
            end
            default: ;
        endcase
    end

endmodule

/* design/mips_core.sv */
module mips_core (
    input  logic                             clk,
    input  logic                             rst,
    output logic [mips_pkg::imem_addr_w-1:0] imem_addr,
    input  logic [mips_pkg::xlen-1:0]        imem_data,
    output mips_pkg::dmem_req_t              dmem_req,
    input  logic [mips_pkg::xlen-1:0]        dmem_rdata,
    output logic                             integer_overflow
);
    import mips_pkg::*;

    logic [xlen-1:0] ins;
    decoded_t        dec;
    ctrl_t           ctrl;
    logic            alu_zero;

    mips_decoder u_decoder (
        .ins (ins),
        .dec (dec)
    );

    mips_control u_control (
        .clk      (clk),
        .rst      (rst),
        .dec      (dec),
        .alu_zero (alu_zero),
        .ctrl     (ctrl)
    );

    mips_datapath u_datapath (
        .clk              (clk),
        .rst              (rst),
        .ctrl             (ctrl),
        .dec              (dec),
        .ins              (ins),
        .alu_zero         (alu_zero),
        .imem_addr        (imem_addr),
        .imem_data        (imem_data),
        .dmem_req         (dmem_req),
        .dmem_rdata       (dmem_rdata),
        .integer_overflow (integer_overflow)
    );

endmodule

/* design/mips_datapath.sv */
module mips_datapath (
    input  logic                             clk,
    input  logic                             rst,
    input  mips_pkg::ctrl_t                  ctrl,
    input  mips_pkg::decoded_t               dec,
    output logic [mips_pkg::xlen-1:0]        ins,
    output logic                             alu_zero,
    output logic [mips_pkg::imem_addr_w-1:0] imem_addr,
    input  logic [mips_pkg::xlen-1:0]        imem_data,
    output mips_pkg::dmem_req_t              dmem_req,
    input  logic [mips_pkg::xlen-1:0]        dmem_rdata,
    output logic                             integer_overflow
);
    import mips_pkg::*;

    logic [xlen-1:0] ir;
    logic [xlen-1:0] a_q;
    logic [xlen-1:0] b_q;
    logic [xlen-1:0] alu_q;
    logic [xlen-1:0] mdr_q;
    logic            ovf_q;

    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       pc_plus4;
    logic [xlen-1:0]       imm_ext;
    logic [xlen-1:0]       alu_b;
    logic [xlen-1:0]       alu_y;
    logic                  alu_ovf;
    logic [xlen-1:0]       rd_data1;
    logic [xlen-1:0]       rd_data2;
    logic [reg_addr_w-1:0] wr_addr;
    logic [xlen-1:0]       wr_data;

    // instruction register loads in fetch only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ir <= '0;
        end else if (ctrl.ir_wr) begin
            ir <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        a_q   <= rd_data1;
        b_q   <= rd_data2;
        alu_q <= alu_y;
        ovf_q <= alu_ovf;
        mdr_q <= dmem_rdata;
    end

    always_comb begin
        case (dec.ext)
            ext_zero:  imm_ext = {{(xlen-imm_w){1'b0}}, ir[imm_w-1:0]};
            ext_upper: imm_ext = {ir[imm_w-1:0], {(xlen-imm_w){1'b0}}};
            default:   imm_ext = {{(xlen-imm_w){ir[imm_w-1]}}, ir[imm_w-1:0]};
        endcase
    end

    assign alu_b = dec.use_imm ? imm_ext : b_q;

    always_comb begin
        if (dec.link) begin
            wr_addr = link_reg;
        end else if (dec.wr_rt) begin
            wr_addr = ir[rt_lsb +: reg_addr_w];
        end else begin
            wr_addr = ir[rd_lsb +: reg_addr_w];
        end
        case (ctrl.wd_sel)
            wd_mem:   wr_data = mdr_q;
            wd_upper: wr_data = imm_ext;
            wd_pc4:   wr_data = pc_plus4;
            default:  wr_data = alu_q;
        endcase
    end

    // trap on alu write-back of a signed op that overflowed
    assign integer_overflow = ctrl.rf_wr && (ctrl.wd_sel == wd_alu) && dec.may_ovf && ovf_q;

    mips_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .wr       (ctrl.rf_wr && !integer_overflow),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_addr1 (ir[rs_lsb +: reg_addr_w]),
        .rd_addr2 (ir[rt_lsb +: reg_addr_w]),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

    mips_alu u_alu (
        .op       (dec.alu_op),
        .a        (a_q),
        .b        (alu_b),
        .y        (alu_y),
        .zero     (alu_zero),
        .overflow (alu_ovf)
    );

    mips_pc_unit u_pc_unit (
        .clk        (clk),
        .rst        (rst),
        .pc_wr      (ctrl.pc_wr),
        .npc_kind   (ctrl.npc_kind),
        .imm_ext    (imm_ext),
        .jump_index (ir[jidx_w-1:0]),
        .pc         (pc),
        .pc_plus4   (pc_plus4)
    );

    assign ins       = ir;
    assign imem_addr = pc[imem_addr_w+1:2];

    always_comb begin
        dmem_req.we    = ctrl.dm_wr;
        dmem_req.addr  = alu_q[dmem_addr_w+1:2];
        dmem_req.wdata = b_q;
    end

endmodule

/* design/mips_decoder.sv */
module mips_decoder (
    input  logic [mips_pkg::xlen-1:0] ins,
    output mips_pkg::decoded_t        dec
);
    import mips_pkg::*;

    opcode_e op;
    funct_e  fn;
    alu_op_e r_op;
    logic    r_ok;

    assign op = opcode_e'(ins[op_lsb +: op_w]);
    assign fn = funct_e'(ins[fn_w-1:0]);

    // register-type function field
    always_comb begin
        r_ok = 1'b1;
        case (fn)
            fn_add, fn_addu: r_op = alu_add;
            fn_sub, fn_subu: r_op = alu_sub;
            fn_slt:          r_op = alu_slt;
            fn_sltu:         r_op = alu_sltu;
            fn_and:          r_op = alu_and;
            fn_or:           r_op = alu_or;
            fn_xor:          r_op = alu_xor;
            fn_nor:          r_op = alu_nor;
            default: begin
                r_op = alu_add;
                r_ok = 1'b0;
            end
        endcase
        // shift amount must be zero for the kept R-type ops
        if (ins[sh_lsb +: reg_addr_w] != '0) begin
            r_ok = 1'b0;
        end
    end

    always_comb begin
        case (op)
            op_special:                    dec.cls = r_ok ? cls_alu : cls_nop;
            op_addi, op_addiu, op_slti,
            op_sltiu, op_andi, op_ori,
            op_xori:                       dec.cls = cls_alu;
            op_lui:                        dec.cls = cls_lui;
            op_lw:                         dec.cls = cls_load;
            op_sw:                         dec.cls = cls_store;
            op_beq, op_bne:                dec.cls = cls_branch;
            op_j, op_jal:                  dec.cls = cls_jump;
            default:                       dec.cls = cls_nop;
        endcase

        case (op)
            op_special:     dec.alu_op = r_op;
            op_slti:        dec.alu_op = alu_slt;
            op_sltiu:       dec.alu_op = alu_sltu;
            op_andi:        dec.alu_op = alu_and;
            op_ori:         dec.alu_op = alu_or;
            op_xori:        dec.alu_op = alu_xor;
            op_beq, op_bne: dec.alu_op = alu_sub;
            default:        dec.alu_op = alu_add;
        endcase

        // logic immediates zero-extend, lui goes to the upper half
        case (op)
            op_andi, op_ori, op_xori: dec.ext = ext_zero;
            op_lui:                   dec.ext = ext_upper;
            default:                  dec.ext = ext_sign;
        endcase

        dec.use_imm = (op != op_special) && (op != op_beq) && (op != op_bne);
        dec.wr_rt   = (op != op_special);
        dec.link    = (op == op_jal);
        dec.may_ovf = (op == op_addi)
                   || ((op == op_special) && (fn == fn_add || fn == fn_sub));
        dec.br_eq   = (op == op_beq);
    end

endmodule

/* design/mips_pc_unit.sv */
module mips_pc_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        pc_wr,
    input  mips_pkg::npc_e              npc_kind,
    input  logic [mips_pkg::xlen-1:0]   imm_ext,
    input  logic [mips_pkg::jidx_w-1:0] jump_index,
    output logic [mips_pkg::xlen-1:0]   pc,
    output logic [mips_pkg::xlen-1:0]   pc_plus4
);
    import mips_pkg::*;

    logic [xlen-1:0] npc;

    assign pc_plus4 = pc + xlen'(4);

    always_comb begin
        case (npc_kind)
            npc_branch: npc = pc_plus4 + {imm_ext[xlen-3:0], 2'b00};
            // keep the region bits of the delay-slot address
            npc_jump:   npc = {pc_plus4[xlen-1 -: 4], jump_index, 2'b00};
            default:    npc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (pc_wr) begin
            pc <= npc;
        end
    end

endmodule

/* design/mips_pkg.sv */
package mips_pkg;

    localparam int xlen        = 32;
    localparam int reg_addr_w  = 5;
    localparam int imem_addr_w = 10;
    localparam int dmem_addr_w = 10;

    localparam logic [reg_addr_w-1:0] link_reg = 5'd31;

    // instruction field positions
    localparam int op_w    = 6;
    localparam int op_lsb  = 26;
    localparam int rs_lsb  = 21;
    localparam int rt_lsb  = 16;
    localparam int rd_lsb  = 11;
    localparam int sh_lsb  = 6;
    localparam int fn_w    = 6;
    localparam int imm_w   = 16;
    localparam int jidx_w  = 26;

    typedef enum logic [op_w-1:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addi    = 6'h08,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_sltiu   = 6'h0b,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    typedef enum logic [fn_w-1:0] {
        fn_add  = 6'h20,
        fn_addu = 6'h21,
        fn_sub  = 6'h22,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_or, alu_xor, alu_nor
    } alu_op_e;

    typedef enum logic [1:0] {ext_zero, ext_sign, ext_upper} ext_e;

    typedef enum logic [2:0] {
        cls_alu, cls_lui, cls_load, cls_store, cls_branch, cls_jump, cls_nop
    } ins_class_e;

    typedef enum logic [3:0] {
        st_fetch, st_decode, st_alu_exe, st_alu_wr, st_lui_wr, st_dm_exe,
        st_dm_load, st_dm_wr, st_dm_store, st_branch_exe, st_jump_exe
    } state_e;

    // register write-back source and next-pc kind
    typedef enum logic [1:0] {wd_alu, wd_mem, wd_upper, wd_pc4} wd_sel_e;
    typedef enum logic [1:0] {npc_seq, npc_branch, npc_jump} npc_e;

    typedef struct packed {
        ins_class_e cls;
        alu_op_e    alu_op;
        ext_e       ext;
        logic       use_imm;
        logic       wr_rt;
        logic       link;
        logic       may_ovf;
        logic       br_eq;
    } decoded_t;

    typedef struct packed {
        logic    ir_wr;
        logic    pc_wr;
        logic    rf_wr;
        logic    dm_wr;
        wd_sel_e wd_sel;
        npc_e    npc_kind;
    } ctrl_t;

    typedef struct packed {
        logic                   we;
        logic [dmem_addr_w-1:0] addr;
        logic [xlen-1:0]        wdata;
    } dmem_req_t;

endpackage

/* design/mips_regfile.sv */
module mips_regfile (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            wr,
    input  logic [mips_pkg::reg_addr_w-1:0] wr_addr,
    input  logic [mips_pkg::xlen-1:0]       wr_data,
    input  logic [mips_pkg::reg_addr_w-1:0] rd_addr1,
    input  logic [mips_pkg::reg_addr_w-1:0] rd_addr2,
    output logic [mips_pkg::xlen-1:0]       rd_data1,
    output logic [mips_pkg::xlen-1:0]       rd_data2
);
    import mips_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wr && wr_addr != '0) begin
            // register zero never changes
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary -Wno-fatal --top-module tb_mips -f sim.f -o tb_mips_sim \
    && ./obj_dir/tb_mips_sim | grep -q "Simulation finished: PASS" \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }

/* sim.f */
design/mips_pkg.sv
design/mips_alu.sv
design/mips_regfile.sv
design/mips_pc_unit.sv
design/mips_decoder.sv
design/mips_control.sv
design/mips_datapath.sv
design/mips_core.sv
tb/mips_checker.sv
tb/tb_mips.sv

/* tb/mips_checker.sv */
module mips_checker (
    input  logic                             clk,
    input  logic                             rst,
    input  mips_pkg::dmem_req_t              dmem_req,
    input  logic                             integer_overflow,
    input  logic [mips_pkg::imem_addr_w-1:0] imem_addr,
    input  logic [mips_pkg::dmem_addr_w-1:0] st_addr [64],
    input  logic [mips_pkg::xlen-1:0]        st_data [64],
    input  logic [2:0]                       st_test [64],
    input  int                               n_st,
    input  logic [mips_pkg::imem_addr_w-1:0] ov_addr [16],
    input  logic [2:0]                       ov_test [16],
    input  int                               n_ov,
    output logic                             done,
    output int                               errors,
    output int                               tests_ok
);
    import mips_pkg::*;

    int st_idx;
    int ov_idx;
    int seen [1:5];
    int bad [1:5];

    initial begin
        st_idx   = 0;
        ov_idx   = 0;
        errors   = 0;
        tests_ok = 0;
        for (int t = 1; t <= 5; t++) begin
            seen[t] = 0;
            bad[t]  = 0;
        end
    end

    assign done = (st_idx == n_st) && (ov_idx == n_ov);

    function automatic int expected_count(int t);
        int n;
        n = 0;
        for (int i = 0; i < n_st; i++) begin
            if (int'(st_test[i]) == t) n++;
        end
        for (int i = 0; i < n_ov; i++) begin
            if (int'(ov_test[i]) == t) n++;
        end
        return n;
    endfunction

    function automatic string test_name(int t);
        case (t)
            1: return "register alu";
            2: return "immediate alu and lui";
            3: return "load store round trip";
            4: return "branches and jumps";
            default: return "overflow";
        endcase
    endfunction

    // a test is reported once its last expected event has been seen
    task automatic close_event(int t, logic good);
        if (!good) bad[t]++;
        seen[t]++;
        if (seen[t] == expected_count(t)) begin
            $display("test %0d %s: %s (%0d events)", t, test_name(t),
                     (bad[t] == 0) ? "ok" : "failed", seen[t]);
            if (bad[t] == 0) tests_ok++;
        end
    endtask

    task automatic check_store();
        logic good;
        if (st_idx >= n_st) begin
            $display("unexpected store at time %0t to word %0d with data %h",
                     $time, dmem_req.addr, dmem_req.wdata);
            errors++;
        end else begin
            good = (dmem_req.addr == st_addr[st_idx]) && (dmem_req.wdata == st_data[st_idx]);
            if (!good) begin
                $display("MISMATCH at %0t: store %0d expected %0d/%h, got %0d/%h",
                         $time, st_idx, st_addr[st_idx], st_data[st_idx],
                         dmem_req.addr, dmem_req.wdata);
                errors++;
            end
            close_event(int'(st_test[st_idx]), good);
            st_idx++;
        end
    endtask

    task automatic check_overflow();
        logic good;
        if (ov_idx >= n_ov) begin
            $display("unexpected overflow pulse at time %0t from instruction word %0d",
                     $time, imem_addr);
            errors++;
        end else begin
            good = (imem_addr == ov_addr[ov_idx]);
            if (!good) begin
                $display("MISMATCH at %0t: overflow %0d expected at word %0d, got word %0d",
                         $time, ov_idx, ov_addr[ov_idx], imem_addr);
                errors++;
            end
            close_event(int'(ov_test[ov_idx]), good);
            ov_idx++;
        end
    endtask

    // outputs are settled before the edge
    always @(posedge clk) begin
        if (!rst) begin
            if (dmem_req.we) check_store();
            if (integer_overflow) check_overflow();
        end
    end

endmodule

/* tb/tb_mips.sv */
module tb_mips;
    import mips_pkg::*;

    localparam int max_st    = 64;
    localparam int max_ov    = 16;
    localparam int run_limit = 20000;

    logic                   clk;
    logic                   rst;
    logic [imem_addr_w-1:0] imem_addr;
    logic [xlen-1:0]        imem_data;
    dmem_req_t              dmem_req;
    logic [xlen-1:0]        dmem_rdata;
    logic                   integer_overflow;

    logic [xlen-1:0] imem [2**imem_addr_w];
    logic [xlen-1:0] dmem [2**dmem_addr_w];
    logic [2:0]      ins_test [2**imem_addr_w];

    // expected events in program order
    logic [dmem_addr_w-1:0] st_addr [max_st];
    logic [xlen-1:0]        st_data [max_st];
    logic [2:0]             st_test [max_st];
    logic [imem_addr_w-1:0] ov_addr [max_ov];
    logic [2:0]             ov_test [max_ov];
    int                     n_st;
    int                     n_ov;

    int                     pc_top;
    int                     st_off;
    int                     cur_test;
    logic [imem_addr_w-1:0] end_word;
    int                     rst_errors;
    logic                   chk_done;
    int                     chk_errors;
    int                     chk_tests_ok;

    mips_core uut (
        .clk              (clk),
        .rst              (rst),
        .imem_addr        (imem_addr),
        .imem_data        (imem_data),
        .dmem_req         (dmem_req),
        .dmem_rdata       (dmem_rdata),
        .integer_overflow (integer_overflow)
    );

    mips_checker chk (
        .clk              (clk),
        .rst              (rst),
        .dmem_req         (dmem_req),
        .integer_overflow (integer_overflow),
        .imem_addr        (imem_addr),
        .st_addr          (st_addr),
        .st_data          (st_data),
        .st_test          (st_test),
        .n_st             (n_st),
        .ov_addr          (ov_addr),
        .ov_test          (ov_test),
        .n_ov             (n_ov),
        .done             (chk_done),
        .errors           (chk_errors),
        .tests_ok         (chk_tests_ok)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // memories answer in the same cycle
    assign imem_data  = imem[imem_addr];
    assign dmem_rdata = dmem[dmem_req.addr];

    always @(posedge clk) begin
        if (dmem_req.we) begin
            dmem[dmem_req.addr] <= dmem_req.wdata;
        end
    end

    function automatic logic [31:0] enc_r(funct_e fn, int rs, int rt, int rd);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(opcode_e op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] enc_j(opcode_e op, int target_word);
        return {op, 26'(target_word)};
    endfunction

    task automatic emit(logic [31:0] w);
        imem[pc_top]     = w;
        ins_test[pc_top] = 3'(cur_test);
        pc_top++;
    endtask

    task automatic load_const(int r, logic [31:0] v);
        emit(enc_i(op_lui, 0, r, v[31:16]));
        emit(enc_i(op_ori, r, r, v[15:0]));
    endtask

    // each store goes to its own word above r28
    task automatic store_reg(int r);
        emit(enc_i(op_sw, 28, r, 16'(st_off)));
        st_off += 4;
    endtask

    task automatic build_program();
        funct_e  fns [10];
        opcode_e iops [7];
        int      ld_off;
        fns  = '{fn_add, fn_addu, fn_sub, fn_subu, fn_slt, fn_sltu,
                 fn_and, fn_or, fn_xor, fn_nor};
        iops = '{op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori};
        pc_top   = 0;
        st_off   = 0;
        cur_test = 1;
        emit(enc_i(op_ori, 0, 28, 16'h0800));
        emit(enc_i(op_ori, 0, 29, 16'h0400));
        for (int r = 1; r <= 4; r++) begin
            load_const(r, $urandom());
        end
        for (int i = 0; i < 10; i++) begin
            emit(enc_r(fns[i], 1 + 2 * int'($urandom() % 2), 2 + 2 * int'($urandom() % 2), 15));
            store_reg(15);
        end
        cur_test = 2;
        // top immediate bit set so the extension kind shows in the result
        for (int i = 0; i < 7; i++) begin
            emit(enc_i(iops[i], 1, 16, 16'($urandom()) | 16'h8000));
            store_reg(16);
        end
        emit(enc_i(op_lui, 0, 17, 16'($urandom())));
        store_reg(17);
        cur_test = 3;
        // the middle load uses a negative offset
        for (int i = 0; i < 3; i++) begin
            ld_off = int'($urandom() % 64) - ((i == 1) ? 64 : 0);
            emit(enc_i(op_lw, 29, 18, 16'(ld_off * 4)));
            store_reg(18);
        end
        cur_test = 4;
        load_const(5, $urandom());
        load_const(6, $urandom());
        // beq taken, beq not taken, bne taken, bne not taken
        for (int k = 0; k < 4; k++) begin
            emit(enc_i(op_ori, 0, 20, 16'($urandom())));
            emit(enc_i(k < 2 ? op_beq : op_bne, 5, (k == 0 || k == 3) ? 5 : 6, 16'd1));
            emit(enc_i(op_ori, 0, 20, 16'($urandom())));
            store_reg(20);
        end
        emit(enc_j(op_jal, pc_top + 2));
        emit(enc_i(op_ori, 0, 20, 16'($urandom())));
        store_reg(31);
        emit(enc_j(op_j, pc_top + 2));
        emit(enc_i(op_ori, 0, 20, 16'($urandom())));
        store_reg(20);
        cur_test = 5;
        load_const(7, 32'h7fffff00 | ($urandom() & 32'hff));
        load_const(8, 32'h70000000 | ($urandom() & 32'hffff));
        load_const(12, 32'h80000000 | ($urandom() & 32'hffff));
        load_const(10, $urandom());
        load_const(11, $urandom());
        load_const(13, $urandom());
        emit(enc_r(fn_add, 7, 8, 10));
        store_reg(10);
        emit(enc_i(op_addi, 7, 11, 16'h7fff));
        store_reg(11);
        emit(enc_r(fn_sub, 12, 7, 13));
        store_reg(13);
        emit(enc_r(fn_addu, 7, 8, 14));
        store_reg(14);
        end_word = imem_addr_w'(pc_top);
        emit(enc_j(op_j, pc_top));
    endtask

    function automatic logic out_of_range(longint w);
        return (w > 64'sd2147483647) || (w < -64'sd2147483648);
    endfunction

    // software model of the subset run over the built program
    function automatic void run_reference();
        logic [31:0] regs [32];
        logic [31:0] mem [2**dmem_addr_w];
        logic [31:0] pc;
        logic [31:0] nxt;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_s;
        logic [31:0] imm_z;
        logic [31:0] res;
        logic [31:0] tgt;
        logic [4:0]  dst;
        logic        wr;
        logic        ovf;
        logic        halted;
        longint      wide;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 2**dmem_addr_w; i++) begin
            mem[i] = dmem[i];
        end
        n_st   = 0;
        n_ov   = 0;
        pc     = '0;
        halted = 1'b0;
        steps  = 0;
        while (!halted && steps < 4000) begin
            ins   = imem[pc[11:2]];
            a     = regs[ins[25:21]];
            b     = regs[ins[20:16]];
            imm_s = {{16{ins[15]}}, ins[15:0]};
            imm_z = {16'h0, ins[15:0]};
            nxt   = pc + 4;
            dst   = ins[20:16];
            wr    = 1'b0;
            ovf   = 1'b0;
            res   = '0;
            tgt   = {nxt[31:28], ins[25:0], 2'b00};
            case (ins[31:26])
                6'h00: begin
                    dst = ins[15:11];
                    wr  = (ins[10:6] == 5'd0);
                    case (ins[5:0])
                        6'h20: begin
                            wide = longint'($signed(a)) + longint'($signed(b));
                            res  = a + b;
                            ovf  = out_of_range(wide);
                        end
                        6'h21: res = a + b;
                        6'h22: begin
                            wide = longint'($signed(a)) - longint'($signed(b));
                            res  = a - b;
                            ovf  = out_of_range(wide);
                        end
                        6'h23: res = a - b;
                        6'h24: res = a & b;
                        6'h25: res = a | b;
                        6'h26: res = a ^ b;
                        6'h27: res = ~(a | b);
                        6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        6'h2b: res = (a < b) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                    ovf = ovf && wr;
                end
                6'h08: begin
                    wide = longint'($signed(a)) + longint'($signed(imm_s));
                    res  = a + imm_s;
                    ovf  = out_of_range(wide);
                    wr   = 1'b1;
                end
                6'h09: begin
                    res = a + imm_s;
                    wr  = 1'b1;
                end
                6'h0a: begin
                    res = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
                    wr  = 1'b1;
                end
                6'h0b: begin
                    res = (a < imm_s) ? 32'd1 : 32'd0;
                    wr  = 1'b1;
                end
                6'h0c: begin
                    res = a & imm_z;
                    wr  = 1'b1;
                end
                6'h0d: begin
                    res = a | imm_z;
                    wr  = 1'b1;
                end
                6'h0e: begin
                    res = a ^ imm_z;
                    wr  = 1'b1;
                end
                6'h0f: begin
                    res = {ins[15:0], 16'h0};
                    wr  = 1'b1;
                end
                6'h23: begin
                    res = mem[dmem_addr_w'((a + imm_s) >> 2)];
                    wr  = 1'b1;
                end
                6'h2b: begin
                    if (n_st < max_st) begin
                        st_addr[n_st] = dmem_addr_w'((a + imm_s) >> 2);
                        st_data[n_st] = b;
                        st_test[n_st] = ins_test[pc[11:2]];
                        n_st++;
                    end
                    mem[dmem_addr_w'((a + imm_s) >> 2)] = b;
                end
                6'h04: begin
                    if (a == b) nxt = pc + 4 + (imm_s << 2);
                end
                6'h05: begin
                    if (a != b) nxt = pc + 4 + (imm_s << 2);
                end
                6'h02: begin
                    halted = (tgt == pc);
                    nxt    = tgt;
                end
                6'h03: begin
                    regs[31] = pc + 4;
                    nxt      = tgt;
                end
                default: ;
            endcase
            if (ovf) begin
                if (n_ov < max_ov) begin
                    ov_addr[n_ov] = pc[11:2];
                    ov_test[n_ov] = ins_test[pc[11:2]];
                    n_ov++;
                end
            end else if (wr && dst != 5'd0) begin
                regs[dst] = res;
            end
            pc = nxt;
            steps++;
        end
    endfunction

    task automatic check_reset_outputs();
        if (dmem_req.we || integer_overflow || imem_addr != '0) begin
            $display("MISMATCH at %0t: reset state we %b ovf %b fetch word %0d",
                     $time, dmem_req.we, integer_overflow, imem_addr);
            rst_errors++;
        end
    endtask

    initial begin
        int cycles;
        void'($urandom(32'h3802db4a));
        rst        = 1'b1;
        rst_errors = 0;
        n_st       = 0;
        n_ov       = 0;
        for (int i = 0; i < 2**imem_addr_w; i++) begin
            imem[i]     = '0;
            ins_test[i] = '0;
        end
        for (int i = 0; i < 2**dmem_addr_w; i++) begin
            dmem[i] = $urandom();
        end
        build_program();
        run_reference();

        repeat (10) begin
            @(negedge clk);
            check_reset_outputs();
        end
        @(posedge clk);
        rst <= 1'b0;
        // first fetch right after release
        @(negedge clk);
        check_reset_outputs();
        $display("test 6 reset state: %s", (rst_errors == 0) ? "ok" : "failed");

        cycles = 0;
        while (!(chk_done && imem_addr == end_word) && cycles < run_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= run_limit) begin
            $display("timeout: program never reached its final jump with all events seen");
            $display("Simulation finished: FAIL");
        end else begin
            $display("tests passed: %0d of 6, errors: %0d",
                     chk_tests_ok + ((rst_errors == 0) ? 1 : 0), chk_errors + rst_errors);
            if (chk_errors == 0 && rst_errors == 0 && chk_tests_ok == 5) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
        end
        $finish;
    end

endmodule
